// File: Bender.yml
package:
  name: uart_regs

export_include_dirs:
  - design

sources:
  - design/uart_regs_pkg.sv
  - design/uart_wr_decode.sv
  - design/uart_ctrl_regs.sv
  - design/uart_status_sample.sv
  - design/uart_rd_mux.sv
  - design/uart_regs_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/uart_regs_tb.sv

// File: design/uart_ctrl_regs.sv
`timescale 1ns/1ps
`include "uart_regs_macros.svh"

// Control registers driving the UART core
module uart_ctrl_regs
    import uart_regs_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  wr_en_t     wr_en,
    input  bus_data_t  wdata,
    output uart_ctrl_t ctrl
);

    uart_byte_t wr_byte;                // Only the low byte carries data

    assign wr_byte = wdata[`UART_BYTE_W-1:0];

    // --------------------
    // Register file
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl <= '0;
        end else begin
            if (wr_en.thr) begin
                ctrl.thr <= wr_byte;                    // Tx holding byte
            end
            if (wr_en.ier) begin
                ctrl.ier <= ier_t'(wr_byte[`UART_IER_W-1:0]);   // Upper nibble dropped
            end
            if (wr_en.fcr) begin
                ctrl.fcr.rxfiftl  <= wr_byte[7:6];
                ctrl.fcr.rsvd     <= '0;                // Bits 5:4 stay clear
                ctrl.fcr.dmamode1 <= wr_byte[3];
                ctrl.fcr.txclr    <= wr_byte[2];
                ctrl.fcr.rxclr    <= wr_byte[1];
                ctrl.fcr.fifoen   <= wr_byte[0];
            end
            if (wr_en.lcr) begin
                // DLAB kept as plain storage
                ctrl.lcr <= lcr_t'(wr_byte);
            end
            if (wr_en.scr) begin
                ctrl.scr <= wr_byte;                    // Scratch pad
            end
            // Divisor bytes not gated by DLAB
            if (wr_en.dll) begin
                ctrl.dll <= wr_byte;
            end
            if (wr_en.dlh) begin
                ctrl.dlh <= wr_byte;
            end
        end
    end

    // --------------------
    // Checks
    // --------------------
    // A cycle without any enable leaves the core config untouched
    a_ctrl_hold: assert property (
        @(posedge clk) disable iff (!reset_n)
        (wr_en == '0) |=> $stable(ctrl)
    ) else $error("ctrl changed without a write enable");

endmodule

// File: design/uart_rd_mux.sv
`timescale 1ns/1ps
`include "uart_regs_macros.svh"

// Read select, zero extend and ack in the strobe cycle
module uart_rd_mux
    import uart_regs_pkg::*;
(
    input  logic         rstrobe,
    input  reg_addr_t    raddr,
    input  uart_ctrl_t   ctrl,
    input  uart_status_t status_q,
    output bus_data_t    rdata,
    output logic         rack,
    output logic         raddrerr
);

    uart_byte_t rd_byte;                // Selected register before extension

    // --------------------
    // Register select
    // --------------------
    always_comb begin
        rd_byte  = '0;
        raddrerr = 1'b0;
        if (rstrobe) begin
            case (raddr)
                `UART_OFS_RBR_THR: rd_byte = status_q.rbr;      // THR not readable
                `UART_OFS_IER:     rd_byte = uart_byte_t'(ctrl.ier);
                `UART_OFS_IIR_FCR: rd_byte = status_q.iir;      // FCR not readable
                `UART_OFS_LCR:     rd_byte = ctrl.lcr;
                `UART_OFS_LSR:     rd_byte = status_q.lsr;
                `UART_OFS_SCR:     rd_byte = ctrl.scr;
                `UART_OFS_DLL:     rd_byte = ctrl.dll;
                `UART_OFS_DLH:     rd_byte = ctrl.dlh;
                default:           raddrerr = 1'b1;            // Reads back zero
            endcase
        end
    end

    // Zero extend to the bus word
    assign rdata = {{(`UART_DATA_W-`UART_BYTE_W){1'b0}}, rd_byte};
    assign rack  = rstrobe;

    // --------------------
    // Checks
    // --------------------
    // Idle bus stays quiet, errors always come with an ack
    always_comb begin
        a_rd_idle: assert #0 (rstrobe || (rdata == '0))
            else $error("rdata nonzero without rstrobe");
        a_rd_err_ack: assert #0 (!raddrerr || rack)
            else $error("raddrerr without rack");
    end

endmodule

// File: design/uart_regs_macros.svh
`ifndef UART_REGS_MACROS_SVH
`define UART_REGS_MACROS_SVH

// --------------------
// Bus and register widths
// --------------------
`define UART_ADDR_W 12                  // Strobe bus address
`define UART_DATA_W 32                  // Strobe bus data
`define UART_BYTE_W 8                   // One UART register

// --------------------
// Register offsets
// --------------------
// Shared offsets, read side first
`define UART_OFS_RBR_THR 12'h000        // Read RBR, write THR
`define UART_OFS_IER     12'h004
`define UART_OFS_IIR_FCR 12'h008        // Read IIR, write FCR
`define UART_OFS_LCR     12'h00C
`define UART_OFS_LSR     12'h014        // Read only
`define UART_OFS_SCR     12'h01C
`define UART_OFS_DLL     12'h020        // Divisor low byte
`define UART_OFS_DLH     12'h024        // Divisor high byte

// Field widths inside a register byte
`define UART_IER_W    4                 // Only the four enables stored
`define UART_RSVD_W   2                 // Reserved pair in FCR and IIR

// MCR, MSR, MDR and STT slots are not decoded

`endif

// File: design/uart_regs_pkg.sv
`include "uart_regs_macros.svh"

package uart_regs_pkg;

    // --------------------
    // Plain vectors
    // --------------------
    typedef logic [`UART_ADDR_W-1:0] reg_addr_t;    // Byte address on the strobe bus
    typedef logic [`UART_DATA_W-1:0] bus_data_t;    // Bus word
    typedef logic [`UART_BYTE_W-1:0] uart_byte_t;   // One register

    // --------------------
    // Register layouts
    // --------------------
    typedef struct packed {
        logic edssi;                    // Modem status irq enable
        logic elsi;                     // Line status irq enable
        logic etbei;                    // THR empty irq enable
        logic erbi;                     // Rx data available irq enable
    } ier_t;

    typedef struct packed {
        logic [1:0]              rxfiftl;   // Rx trigger level
        logic [`UART_RSVD_W-1:0] rsvd;      // Always zero
        logic                    dmamode1;
        logic                    txclr;
        logic                    rxclr;
        logic                    fifoen;
    } fcr_t;

    typedef struct packed {
        logic       dlab;               // Stored only, no divisor gating
        logic       bc;                 // Break control
        logic       sp;                 // Stick parity
        logic       eps;                // Even parity select
        logic       pen;                // Parity enable
        logic       stb;                // Stop bits
        logic [1:0] wls;                // Word length
    } lcr_t;

    typedef struct packed {
        logic [1:0]              fifoen;
        logic [`UART_RSVD_W-1:0] rsvd;
        logic [2:0]              intid;     // Interrupt type
        logic                    ipend;     // Low when pending
    } iir_t;

    typedef struct packed {
        logic rxfifoe;
        logic temt;
        logic thre;
        logic bi;
        logic fe;
        logic pe;
        logic oe;
        logic dr;
    } lsr_t;

    // One-hot, one bit per writable register
    typedef struct packed {
        logic thr;
        logic ier;
        logic fcr;
        logic lcr;
        logic scr;
        logic dll;
        logic dlh;
    } wr_en_t;

    // --------------------
    // Core facing bundles
    // --------------------
    typedef struct packed {
        uart_byte_t thr;
        ier_t       ier;
        fcr_t       fcr;
        lcr_t       lcr;
        uart_byte_t scr;
        uart_byte_t dll;
        uart_byte_t dlh;
    } uart_ctrl_t;

    typedef struct packed {
        uart_byte_t rbr;
        iir_t       iir;
        lsr_t       lsr;
    } uart_status_t;

endpackage

// File: design/uart_regs_top.sv
`timescale 1ns/1ps
`include "uart_regs_macros.svh"

// Register bank for the UART core on a plain strobe bus
module uart_regs_top
    import uart_regs_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    // Write side
    input  logic         wstrobe,
    input  reg_addr_t    waddr,
    input  bus_data_t    wdata,
    output logic         wack,
    output logic         waddrerr,
    // Read side
    input  logic         rstrobe,
    input  reg_addr_t    raddr,
    output bus_data_t    rdata,
    output logic         rack,
    output logic         raddrerr,
    // UART core
    output uart_ctrl_t   ctrl,
    input  uart_status_t status
);

    wr_en_t       wr_en;                // Decoded register select
    uart_status_t status_q;             // Status one clock behind the core

    // --------------------
    // Write path
    // --------------------
    uart_wr_decode u_wr_decode (
        .wstrobe  (wstrobe),
        .waddr    (waddr),
        .wr_en    (wr_en),
        .wack     (wack),
        .waddrerr (waddrerr)
    );

    uart_ctrl_regs u_ctrl_regs (
        .clk     (clk),
        .reset_n (reset_n),
        .wr_en   (wr_en),
        .wdata   (wdata),
        .ctrl    (ctrl)
    );

    // --------------------
    // Status and read path
    // --------------------
    uart_status_sample u_status_sample (
        .clk      (clk),
        .reset_n  (reset_n),
        .status   (status),
        .status_q (status_q)
    );

    uart_rd_mux u_rd_mux (
        .rstrobe  (rstrobe),
        .raddr    (raddr),
        .ctrl     (ctrl),               // Value before the current edge
        .status_q (status_q),
        .rdata    (rdata),
        .rack     (rack),
        .raddrerr (raddrerr)
    );

endmodule

// File: design/uart_status_sample.sv
`timescale 1ns/1ps
`include "uart_regs_macros.svh"

// Status capture one clock behind the core
module uart_status_sample
    import uart_regs_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  uart_status_t status,
    output uart_status_t status_q
);

    uart_status_t status_clean;         // Reserved bits forced low

    // --------------------
    // Masking
    // --------------------
    always_comb begin
        status_clean          = status;
        status_clean.iir.rsvd = '0;     // IIR 5:4 read as zero
    end

    // --------------------
    // Capture every clock
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            status_q <= '0;
        end else begin
            status_q <= status_clean;   // Stable copy for the read mux
        end
    end

endmodule

// File: design/uart_wr_decode.sv
`timescale 1ns/1ps
`include "uart_regs_macros.svh"

// Write address decode, acked in the strobe cycle
module uart_wr_decode
    import uart_regs_pkg::*;
(
    input  logic      wstrobe,
    input  reg_addr_t waddr,
    output wr_en_t    wr_en,
    output logic      wack,
    output logic      waddrerr
);

    // --------------------
    // Decode
    // --------------------
    always_comb begin
        wr_en    = '0;
        waddrerr = 1'b0;
        if (wstrobe) begin
            case (waddr)
                `UART_OFS_RBR_THR: wr_en.thr = 1'b1;    // Offset 0 writes THR
                `UART_OFS_IER:     wr_en.ier = 1'b1;
                `UART_OFS_IIR_FCR: wr_en.fcr = 1'b1;    // Offset 8 writes FCR
                `UART_OFS_LCR:     wr_en.lcr = 1'b1;
                `UART_OFS_SCR:     wr_en.scr = 1'b1;
                `UART_OFS_DLL:     wr_en.dll = 1'b1;
                `UART_OFS_DLH:     wr_en.dlh = 1'b1;
                // LSR, dropped slots and the rest
                default:           waddrerr  = 1'b1;
            endcase
        end
    end

    assign wack = wstrobe;              // Every strobe done in its own cycle

    // --------------------
    // Checks
    // --------------------
    // No strobe must mean no register load downstream
    always_comb begin
        a_wr_en_onehot: assert #0 ($onehot0(wr_en) && (wstrobe || (wr_en == '0)))
            else $error("wr_en not one-hot or set without wstrobe");
    end

endmodule

// File: dv/uart_regs_tb_checks.svh
`ifndef UART_REGS_TB_CHECKS_SVH
`define UART_REGS_TB_CHECKS_SVH

// --------------------
// Compare tasks
// --------------------
task automatic check_data(input string what, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
        data_errs++;
        $display("Fail at %0t ns: %s returned %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_ctrl(input uart_ctrl_t got, input uart_ctrl_t exp);
    if (got !== exp) begin
        ctrl_errs++;
        $display("Fail at %0t ns: ctrl is %h, expected %h", $time, got, exp);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        flag_errs++;
        $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// --------------------
// Bus accesses
// --------------------
// One access per cycle driven on the falling edge
task automatic write_reg(input reg_addr_t addr, input bus_data_t data);
    @(negedge clk);
    wstrobe = 1'b1;
    waddr   = addr;
    wdata   = data;
    rstrobe = 1'b0;
endtask

task automatic read_reg(input reg_addr_t addr);
    @(negedge clk);
    wstrobe = 1'b0;
    rstrobe = 1'b1;
    raddr   = addr;
endtask

task automatic idle_cycle();
    @(negedge clk);
    wstrobe = 1'b0;
    rstrobe = 1'b0;
endtask

// New core status with the strobes idle
task automatic drive_status(input uart_status_t value);
    idle_cycle();
    status = value;
endtask

`endif

// File: dv/uart_regs_tb.sv
`timescale 1ns/1ps
`include "uart_regs_macros.svh"

module uart_regs_tb
    import uart_regs_pkg::*;
;

    localparam int max_cycles = 600;    // About twice the access count

    logic         clk;
    logic         reset_n;
    logic         wstrobe;
    reg_addr_t    waddr;
    bus_data_t    wdata;
    logic         rstrobe;
    reg_addr_t    raddr;
    uart_status_t status;
    bus_data_t    rdata;
    logic         wack;
    logic         waddrerr;
    logic         rack;
    logic         raddrerr;
    uart_ctrl_t   ctrl;

    int           data_errs = 0;
    int           ctrl_errs = 0;
    int           flag_errs = 0;
    int           cycles    = 0;
    integer       seed      = 32'h4e60_278b;

    uart_ctrl_t   shadow;               // Expected control state
    uart_status_t status_prev;          // Status driven one cycle earlier

    reg_addr_t rw_addrs [5] = '{`UART_OFS_IER, `UART_OFS_LCR, `UART_OFS_SCR,
                                `UART_OFS_DLL, `UART_OFS_DLH};
    reg_addr_t rd_addrs [8] = '{`UART_OFS_RBR_THR, `UART_OFS_IER, `UART_OFS_IIR_FCR,
                                `UART_OFS_LCR, `UART_OFS_LSR, `UART_OFS_SCR,
                                `UART_OFS_DLL, `UART_OFS_DLH};
    reg_addr_t bad_addrs [5] = '{12'h010, 12'h018, 12'h028, 12'h02C, 12'h100};

    `include "uart_regs_tb_checks.svh"

    uart_regs_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;         // 20 ns period
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic logic wr_mapped(input reg_addr_t addr);
        return addr inside {`UART_OFS_RBR_THR, `UART_OFS_IER, `UART_OFS_IIR_FCR,
                            `UART_OFS_LCR, `UART_OFS_SCR, `UART_OFS_DLL, `UART_OFS_DLH};
    endfunction

    // IER keeps the low nibble and FCR drops bits 5:4
    function automatic void apply_write(input reg_addr_t addr, input bus_data_t data);
        case (addr)
            `UART_OFS_RBR_THR: shadow.thr = data[7:0];
            `UART_OFS_IER:     shadow.ier = data[3:0];
            `UART_OFS_IIR_FCR: shadow.fcr = data[7:0] & 8'hCF;
            `UART_OFS_LCR:     shadow.lcr = data[7:0];
            `UART_OFS_SCR:     shadow.scr = data[7:0];
            `UART_OFS_DLL:     shadow.dll = data[7:0];
            `UART_OFS_DLH:     shadow.dlh = data[7:0];
            default:           ;
        endcase
    endfunction

    function automatic bus_data_t ref_read(input logic strobe, input reg_addr_t addr,
                                           output logic err);
        uart_byte_t b;
        b   = 8'h00;
        err = 1'b0;
        if (strobe) begin
            case (addr)
                `UART_OFS_RBR_THR: b = status_prev.rbr;             // RBR, never THR
                `UART_OFS_IER:     b = {4'h0, shadow.ier};
                `UART_OFS_IIR_FCR: b = status_prev.iir & 8'hCF;     // IIR 5:4 reserved
                `UART_OFS_LCR:     b = shadow.lcr;
                `UART_OFS_LSR:     b = status_prev.lsr;
                `UART_OFS_SCR:     b = shadow.scr;
                `UART_OFS_DLL:     b = shadow.dll;
                `UART_OFS_DLH:     b = shadow.dlh;
                default:           err = 1'b1;
            endcase
        end
        return {24'h0, b};
    endfunction

    // --------------------
    // Compare on the edge that ends each cycle
    // --------------------
    always @(posedge clk) begin
        bus_data_t exp_data;
        logic      exp_err;
        if (!reset_n) begin
            shadow      = '0;
            status_prev = '0;
        end else begin
            check_ctrl(ctrl, shadow);   // Writes up to the previous edge
            check_flag("wack", wack, wstrobe);
            check_flag("rack", rack, rstrobe);
            check_flag("waddrerr", waddrerr, wstrobe && !wr_mapped(waddr));
            if (wstrobe && wr_mapped(waddr)) begin
                apply_write(waddr, wdata);
            end
            exp_data = ref_read(rstrobe, raddr, exp_err);
            check_data($sformatf("read at %h", raddr), rdata, exp_data);
            check_flag("raddrerr", raddrerr, exp_err);
            status_prev = status;       // Seen by the DUT after this edge
        end
    end

    // Run limit
    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display(">>> FAIL");
        $finish;
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        wstrobe = 1'b0;
        waddr   = '0;
        wdata   = '0;
        rstrobe = 1'b0;
        raddr   = '0;
        status  = '0;
        reset_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk) reset_n = 1'b1;

        foreach (rd_addrs[i]) read_reg(rd_addrs[i]);            // Reset values
        for (int i = 0; i < 40; i++) begin
            write_reg(rw_addrs[i % 5], $random(seed));
            read_reg(rw_addrs[i % 5]);
        end

        // THR and FCR alias the RBR and IIR reads
        drive_status(24'($random(seed)));
        for (int i = 0; i < 8; i++) begin
            write_reg(`UART_OFS_RBR_THR, $random(seed));
            write_reg(`UART_OFS_IIR_FCR, $random(seed));
            read_reg(`UART_OFS_RBR_THR);
            read_reg(`UART_OFS_IIR_FCR);
        end

        for (int i = 0; i < 30; i++) begin
            drive_status(24'($random(seed)));
            read_reg(`UART_OFS_RBR_THR);
            read_reg(`UART_OFS_IIR_FCR);
            read_reg(`UART_OFS_LSR);
        end

        foreach (bad_addrs[i]) begin                            // Dropped slots
            write_reg(bad_addrs[i], $random(seed));
            read_reg(bad_addrs[i]);
        end
        repeat (6) idle_cycle();

        $display("Errors: data %0d, ctrl %0d, flag %0d", data_errs, ctrl_errs, flag_errs);
        if (data_errs + ctrl_errs + flag_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: uart_regs.f
+incdir+design
+incdir+dv
design/uart_regs_pkg.sv
design/uart_wr_decode.sv
design/uart_ctrl_regs.sv
design/uart_status_sample.sv
design/uart_rd_mux.sv
design/uart_regs_top.sv
dv/uart_regs_tb.sv
